/* build.f */
traffic_pkg.sv
input_conditioner.sv
intersection_fsm.sv
lamp_driver.sv
traffic_top.sv
traffic_tb.sv

/* input_conditioner.sv */
// Synchronizes the emergency code and pedestrian buttons into the clock domain
// and generates the one-second tick shared by all intersection controllers
`timescale 1ns/1ps

module input_conditioner (
    input  logic                            clk,
    input  logic                            reset_n,
    input  traffic_pkg::emerg_t             emerg_async,
    input  logic [traffic_pkg::NUM_X-1:0]   ped_async,
    output traffic_pkg::emerg_t             emerg,
    output logic [traffic_pkg::NUM_X-1:0]   ped,
    output logic                            sec_tick
);

    // First synchronizer stage
    traffic_pkg::emerg_t            emerg_meta;
    logic [traffic_pkg::NUM_X-1:0]  ped_meta;

    // Prescaler position within the current second
    traffic_pkg::tick_count_t       tick_cnt;

    // Two flops per bit, output stage drives the controllers directly
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            emerg_meta <= traffic_pkg::EMERG_NONE;
            emerg      <= traffic_pkg::EMERG_NONE;
            ped_meta   <= '0;
            ped        <= '0;
        end else begin
            emerg_meta <= emerg_async;
            emerg      <= emerg_meta;
            ped_meta   <= ped_async;
            ped        <= ped_meta;
        end
    end

    // Wraps at TICK_DIV-1, registered pulse on the wrap
    // First pulse lands TICK_DIV cycles after reset release
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tick_cnt <= '0;
            sec_tick <= 1'b0;
        end else if (tick_cnt == traffic_pkg::TICK_LAST) begin
            tick_cnt <= '0;
            sec_tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            sec_tick <= 1'b0;
        end
    end

    // Tick is a single-cycle pulse, controllers count it once per second
    a_tick_single: assert property (
        @(posedge clk) disable iff (!reset_n) sec_tick |=> !sec_tick
    ) else $error("sec_tick high on two consecutive cycles");

endmodule

/* intersection_fsm.sv */
// Phase controller for one intersection: startup flash, NS/EW green and yellow,
// pedestrian walk and emergency flash. Timers advance only on sec_tick,
// an immediate emergency code overrides any phase on the next clock edge
`timescale 1ns/1ps

module intersection_fsm (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sec_tick,
    input  traffic_pkg::emerg_t     emerg,
    input  logic                    ped,
    output traffic_pkg::light_t     ns_light,
    output traffic_pkg::light_t     ew_light,
    output logic                    walk
);

    traffic_pkg::phase_t        phase;
    traffic_pkg::phase_t        next_phase;

    // Seconds spent in the current phase
    traffic_pkg::sec_count_t    sec_cnt;
    // Seconds spent walking
    traffic_pkg::walk_count_t   walk_cnt;

    logic immed_req;
    logic safe_req;
    logic green_done;
    logic yellow_done;

    // 11 acts at once, 01/10 only at a phase boundary
    assign immed_req = (emerg == traffic_pkg::EMERG_IMMED);
    assign safe_req  = (emerg != traffic_pkg::EMERG_NONE) && !immed_req;

    // Green cut short when a button is pending at the short limit
    assign green_done  = ((sec_cnt == traffic_pkg::T_GREEN_SHORT) && ped) ||
                         (sec_cnt >= traffic_pkg::T_GREEN_FULL);
    assign yellow_done = (sec_cnt >= traffic_pkg::T_YELLOW);

    // Next phase
    always_comb begin
        next_phase = phase;
        if (immed_req) begin
            // Override from every phase, no tick needed
            next_phase = traffic_pkg::EMERG;
        end else if (sec_tick) begin
            case (phase)
                traffic_pkg::STARTUP: begin
                    if (sec_cnt >= traffic_pkg::T_STARTUP) begin
                        next_phase = traffic_pkg::NS_GREEN;
                    end
                end
                traffic_pkg::NS_GREEN: begin
                    if (green_done) begin
                        next_phase = traffic_pkg::NS_YELLOW;
                    end
                end
                traffic_pkg::NS_YELLOW: begin
                    if (yellow_done) begin
                        if (safe_req) begin
                            next_phase = traffic_pkg::EMERG;
                        end else if (ped) begin
                            next_phase = traffic_pkg::WALK;
                        end else begin
                            next_phase = traffic_pkg::EW_GREEN;
                        end
                    end
                end
                traffic_pkg::EW_GREEN: begin
                    if (green_done) begin
                        next_phase = traffic_pkg::EW_YELLOW;
                    end
                end
                traffic_pkg::EW_YELLOW: begin
                    if (yellow_done) begin
                        if (safe_req) begin
                            next_phase = traffic_pkg::EMERG;
                        end else if (ped) begin
                            next_phase = traffic_pkg::WALK;
                        end else begin
                            next_phase = traffic_pkg::NS_GREEN;
                        end
                    end
                end
                traffic_pkg::WALK: begin
                    // Button released ends the walk early
                    if (!ped) begin
                        next_phase = traffic_pkg::NS_GREEN;
                    end else if (walk_cnt >= traffic_pkg::T_WALK) begin
                        // Safe code honoured only at expiry
                        next_phase = safe_req ? traffic_pkg::EMERG : traffic_pkg::NS_GREEN;
                    end
                end
                traffic_pkg::EMERG: begin
                    if (emerg == traffic_pkg::EMERG_NONE) begin
                        next_phase = traffic_pkg::NS_GREEN;
                    end
                end
                default: begin
                    next_phase = traffic_pkg::STARTUP;
                end
            endcase
        end
    end

    // Phase register and counters
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase    <= traffic_pkg::STARTUP;
            sec_cnt  <= '0;
            walk_cnt <= '0;
        end else begin
            phase <= next_phase;
            if (next_phase != phase) begin
                // Every phase starts counting from zero
                sec_cnt  <= '0;
                walk_cnt <= '0;
            end else if (sec_tick) begin
                if (phase == traffic_pkg::WALK) begin
                    walk_cnt <= walk_cnt + 1'b1;
                end else if (phase != traffic_pkg::EMERG) begin
                    sec_cnt <= sec_cnt + 1'b1;
                end
            end
        end
    end

    // Light decode
    always_comb begin
        ns_light = traffic_pkg::RED;
        ew_light = traffic_pkg::RED;
        walk     = 1'b0;
        case (phase)
            traffic_pkg::STARTUP,
            traffic_pkg::EMERG: begin
                ns_light = traffic_pkg::FLASH;
                ew_light = traffic_pkg::FLASH;
            end
            traffic_pkg::NS_GREEN:  ns_light = traffic_pkg::GREEN;
            traffic_pkg::NS_YELLOW: ns_light = traffic_pkg::YELLOW;
            traffic_pkg::EW_GREEN:  ew_light = traffic_pkg::GREEN;
            traffic_pkg::EW_YELLOW: ew_light = traffic_pkg::YELLOW;
            traffic_pkg::WALK:      walk     = 1'b1;
            default: begin
                ns_light = traffic_pkg::FLASH;
                ew_light = traffic_pkg::FLASH;
            end
        endcase
    end

    // Never a moving-traffic light on both roads together
    a_no_conflict: assert property (
        @(posedge clk) disable iff (!reset_n)
        !((ns_light inside {traffic_pkg::GREEN, traffic_pkg::YELLOW}) &&
          (ew_light inside {traffic_pkg::GREEN, traffic_pkg::YELLOW}))
    ) else $error("Conflicting lights on NS and EW");

    // Pedestrians cross only with both roads held at red
    a_walk_red: assert property (
        @(posedge clk) disable iff (!reset_n)
        walk |-> (ns_light == traffic_pkg::RED) && (ew_light == traffic_pkg::RED)
    ) else $error("Walk shown while a road is not red");

endmodule

/* lamp_driver.sv */
// Turns each intersection's light codes into separate red, yellow and green lamp lines
// Flashing roads blink the yellow lamp at one toggle per second tick
`timescale 1ns/1ps

module lamp_driver (
    input  logic                                            clk,
    input  logic                                            reset_n,
    input  logic                                            sec_tick,
    input  traffic_pkg::light_t [traffic_pkg::NUM_X-1:0]    ns_light,
    input  traffic_pkg::light_t [traffic_pkg::NUM_X-1:0]    ew_light,
    input  logic [traffic_pkg::NUM_X-1:0]                   walk,
    output logic [traffic_pkg::NUM_X-1:0]                   ns_red,
    output logic [traffic_pkg::NUM_X-1:0]                   ns_yellow,
    output logic [traffic_pkg::NUM_X-1:0]                   ns_green,
    output logic [traffic_pkg::NUM_X-1:0]                   ew_red,
    output logic [traffic_pkg::NUM_X-1:0]                   ew_yellow,
    output logic [traffic_pkg::NUM_X-1:0]                   ew_green,
    output logic [traffic_pkg::NUM_X-1:0]                   ped_walk,
    output logic                                            flash_active
);

    // Blink phase, starts dark after reset
    logic blink_on;

    // One code to {red, yellow, green}
    function automatic logic [2:0] lamp_decode(traffic_pkg::light_t code, logic blink);
        logic [2:0] lamps;
        case (code)
            traffic_pkg::RED:    lamps = 3'b100;
            traffic_pkg::YELLOW: lamps = 3'b010;
            traffic_pkg::GREEN:  lamps = 3'b001;
            default:             lamps = {1'b0, blink, 1'b0};
        endcase
        return lamps;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            blink_on <= 1'b0;
        end else if (sec_tick) begin
            blink_on <= !blink_on;
        end
    end

    always_comb begin
        flash_active = 1'b0;
        for (int k = 0; k < traffic_pkg::NUM_X; k++) begin
            {ns_red[k], ns_yellow[k], ns_green[k]} = lamp_decode(ns_light[k], blink_on);
            {ew_red[k], ew_yellow[k], ew_green[k]} = lamp_decode(ew_light[k], blink_on);
            // Any flashing road counts, startup or emergency alike
            if ((ns_light[k] == traffic_pkg::FLASH) || (ew_light[k] == traffic_pkg::FLASH)) begin
                flash_active = 1'b1;
            end
        end
    end

    // Walk lamps follow the controllers directly
    assign ped_walk = walk;

endmodule

/* run.sh */
#!/bin/sh
# Builds the corridor testbench with Verilator and runs it
# Exit status is 0 only when the testbench reports a pass
cd "$(dirname "$0")" || exit 1
out="$(verilator --binary --timing --assert --top-module traffic_tb -f build.f 2>&1 \
    && ./obj_dir/Vtraffic_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1

/* traffic_pkg.sv */
// Shared types and timing constants for the three-intersection corridor controller
// All design files refer to these by scoped name
package traffic_pkg;

    // Intersections along the corridor
    localparam int NUM_X = 3;

    // Clock cycles per scaled second
    localparam int TICK_DIV = 4;
    localparam int TICK_W   = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    typedef logic [TICK_W-1:0] tick_count_t;
    // Phase second counter, wide enough for a full green
    typedef logic [5:0] sec_count_t;
    // Walk second counter
    typedef logic [3:0] walk_count_t;
    // Emergency code, 00 none, 01/10 safe, 11 immediate
    typedef logic [1:0] emerg_t;

    // Prescaler wrap value
    localparam tick_count_t TICK_LAST = tick_count_t'(TICK_DIV - 1);

    // Phase lengths in seconds, transition happens on the tick at the limit
    localparam sec_count_t  T_STARTUP     = 6'd5;
    localparam sec_count_t  T_GREEN_FULL  = 6'd30;
    localparam sec_count_t  T_GREEN_SHORT = 6'd15;
    localparam sec_count_t  T_YELLOW      = 6'd5;
    localparam walk_count_t T_WALK        = 4'd15;

    // Emergency codes with special meaning
    localparam emerg_t EMERG_NONE  = 2'b00;
    localparam emerg_t EMERG_IMMED = 2'b11;

    // Light code per road, FLASH blinks the yellow lamp
    typedef enum logic [1:0] {
        RED    = 2'b00,
        YELLOW = 2'b01,
        GREEN  = 2'b10,
        FLASH  = 2'b11
    } light_t;

    // Controller phases
    typedef enum logic [2:0] {
        STARTUP   = 3'd0,
        NS_GREEN  = 3'd1,
        NS_YELLOW = 3'd2,
        EW_GREEN  = 3'd3,
        EW_YELLOW = 3'd4,
        WALK      = 3'd5,
        EMERG     = 3'd6
    } phase_t;

endpackage

/* traffic_tb.sv */
// Testbench for the three-intersection corridor controller
// Steps through a scenario table, waits for each lamp change and checks
// lamps, walk lines, flash flag and phase lengths in ticks
`timescale 1ns/1ps

module traffic_tb;

    // One scenario step
    // pat holds "<ns><ew> " per intersection using R Y G F
    typedef struct packed {
        traffic_pkg::emerg_t                emerg;
        logic [traffic_pkg::NUM_X-1:0]      ped;
        logic                               rnd;
        logic [24*traffic_pkg::NUM_X-1:0]   pat;
        logic [traffic_pkg::NUM_X-1:0]      walk;
        logic                               flash;
        int                                 exp_ticks;
        int                                 timeout;
    } step_t;

    logic                           clk;
    logic                           reset_n;
    traffic_pkg::emerg_t            emerg_async;
    logic [traffic_pkg::NUM_X-1:0]  ped_async;
    logic [traffic_pkg::NUM_X-1:0]  ns_red;
    logic [traffic_pkg::NUM_X-1:0]  ns_yellow;
    logic [traffic_pkg::NUM_X-1:0]  ns_green;
    logic [traffic_pkg::NUM_X-1:0]  ew_red;
    logic [traffic_pkg::NUM_X-1:0]  ew_yellow;
    logic [traffic_pkg::NUM_X-1:0]  ew_green;
    logic [traffic_pkg::NUM_X-1:0]  ped_walk;
    logic                           flash_active;

    step_t  steps [15];
    int     errors = 0;
    int     timeouts = 0;
    // Free-running cycle count for measuring phase lengths
    int     cyc = 0;
    int     t_mark;
    int     delay;
    int     elapsed;
    logic   seen;

    traffic_top traffic_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .emerg_async  (emerg_async),
        .ped_async    (ped_async),
        .ns_red       (ns_red),
        .ns_yellow    (ns_yellow),
        .ns_green     (ns_green),
        .ew_red       (ew_red),
        .ew_yellow    (ew_yellow),
        .ew_green     (ew_green),
        .ped_walk     (ped_walk),
        .flash_active (flash_active)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Pattern letter to expected code
    function automatic traffic_pkg::light_t code_of(logic [7:0] c);
        case (c)
            "G":     return traffic_pkg::GREEN;
            "Y":     return traffic_pkg::YELLOW;
            "F":     return traffic_pkg::FLASH;
            default: return traffic_pkg::RED;
        endcase
    endfunction

    // Lamp lines back to a code
    // Flashing road is dark or yellow while flash_active is high
    function automatic traffic_pkg::light_t light_of(logic r, logic y, logic g, logic fl);
        if (r) begin
            return traffic_pkg::RED;
        end
        if (g) begin
            return traffic_pkg::GREEN;
        end
        if (y && !fl) begin
            return traffic_pkg::YELLOW;
        end
        return traffic_pkg::FLASH;
    endfunction

    // Blink-independent view of all outputs
    function automatic logic [5*traffic_pkg::NUM_X:0] snapshot();
        logic [5*traffic_pkg::NUM_X:0] s;
        s = '0;
        for (int k = 0; k < traffic_pkg::NUM_X; k++) begin
            s[4*k +: 2]   = light_of(ns_red[k], ns_yellow[k], ns_green[k], flash_active);
            s[4*k+2 +: 2] = light_of(ew_red[k], ew_yellow[k], ew_green[k], flash_active);
        end
        s[4*traffic_pkg::NUM_X +: traffic_pkg::NUM_X] = ped_walk;
        s[5*traffic_pkg::NUM_X] = flash_active;
        return s;
    endfunction

    task automatic check_light(string name, int k, traffic_pkg::light_t got,
                               traffic_pkg::light_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s[%0d] got %h expected %h", name, k, got, exp);
        end
    endtask

    task automatic check_mask(string name, logic [traffic_pkg::NUM_X-1:0] got,
                              logic [traffic_pkg::NUM_X-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // All outputs against one table row
    task automatic check_step(int i);
        for (int k = 0; k < traffic_pkg::NUM_X; k++) begin
            check_light("ns_light", k, light_of(ns_red[k], ns_yellow[k], ns_green[k], flash_active),
                        code_of(steps[i].pat[24*(traffic_pkg::NUM_X-k)-1 -: 8]));
            check_light("ew_light", k, light_of(ew_red[k], ew_yellow[k], ew_green[k], flash_active),
                        code_of(steps[i].pat[24*(traffic_pkg::NUM_X-k)-9 -: 8]));
        end
        check_mask("ped_walk", ped_walk, steps[i].walk);
        check_flag("flash_active", flash_active, steps[i].flash);
    endtask

    // Waits for any output change within the row's tick budget
    task automatic wait_change(int idx, int ticks, output logic changed);
        logic [5*traffic_pkg::NUM_X:0] start;
        int n;
        start = snapshot();
        n = 0;
        while (snapshot() === start && n < ticks * traffic_pkg::TICK_DIV) begin
            @(negedge clk);
            n++;
        end
        changed = (snapshot() !== start);
        if (!changed) begin
            timeouts++;
            $display("Timeout: step %0d showed no change within %0d ticks", idx, ticks);
        end
    endtask

    // Startup flash has yellows toggling once per tick with red and green dark
    task automatic check_blink();
        int n;
        logic lit;
        n = 0;
        while (ns_yellow[0] !== 1'b1 && n < 2 * traffic_pkg::TICK_DIV) begin
            @(negedge clk);
            n++;
        end
        if (ns_yellow[0] !== 1'b1) begin
            timeouts++;
            $display("Timeout: flashing yellow never lit during startup");
        end else begin
            lit = 1'b1;
            repeat (4) begin
                check_mask("ns_yellow", ns_yellow, {traffic_pkg::NUM_X{lit}});
                check_mask("ew_yellow", ew_yellow, {traffic_pkg::NUM_X{lit}});
                check_mask("red_green", ns_red | ns_green | ew_red | ew_green, '0);
                lit = !lit;
                repeat (traffic_pkg::TICK_DIV) @(negedge clk);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        emerg_async = traffic_pkg::EMERG_NONE;
        ped_async = '0;
        void'($urandom(91491));
        // Phase lengths in ticks are startup 6, green 31, short green 16 and yellow 6
        steps[0]  = '{2'b00, 3'b000, 1'b0, "FF FF FF ", 3'b000, 1'b1, 0, 0};
        steps[1]  = '{2'b00, 3'b000, 1'b0, "GR GR GR ", 3'b000, 1'b0, 6, 10};
        steps[2]  = '{2'b00, 3'b000, 1'b0, "YR YR YR ", 3'b000, 1'b0, 31, 36};
        steps[3]  = '{2'b00, 3'b000, 1'b0, "RG RG RG ", 3'b000, 1'b0, 6, 10};
        steps[4]  = '{2'b00, 3'b000, 1'b0, "RY RY RY ", 3'b000, 1'b0, 31, 36};
        steps[5]  = '{2'b00, 3'b000, 1'b0, "GR GR GR ", 3'b000, 1'b0, 6, 10};
        // Button on intersection 1 pressed at a random second of the green
        steps[6]  = '{2'b00, 3'b010, 1'b1, "GR YR GR ", 3'b000, 1'b0, 16, 20};
        steps[7]  = '{2'b00, 3'b010, 1'b0, "GR RR GR ", 3'b010, 1'b0, 6, 10};
        steps[8]  = '{2'b00, 3'b000, 1'b0, "GR GR GR ", 3'b000, 1'b0, 1, 3};
        // Neighbours still on full timing until 31 ticks after their green began
        steps[9]  = '{2'b00, 3'b000, 1'b0, "YR GR YR ", 3'b000, 1'b0, 8, 12};
        // Immediate code within the 4-cycle limit of one tick
        steps[10] = '{2'b11, 3'b000, 1'b0, "FF FF FF ", 3'b000, 1'b1, 0, 1};
        steps[11] = '{2'b00, 3'b000, 1'b0, "GR GR GR ", 3'b000, 1'b0, 1, 3};
        // Safe code waits for the end of the yellow
        steps[12] = '{2'b01, 3'b000, 1'b0, "YR YR YR ", 3'b000, 1'b0, 31, 36};
        steps[13] = '{2'b01, 3'b000, 1'b0, "FF FF FF ", 3'b000, 1'b1, 6, 10};
        steps[14] = '{2'b00, 3'b000, 1'b0, "GR GR GR ", 3'b000, 1'b0, 1, 3};

        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        t_mark = cyc;
        for (int i = 0; i < $size(steps); i++) begin
            if (steps[i].rnd) begin
                delay = $urandom % 11;
                repeat (delay * traffic_pkg::TICK_DIV) @(negedge clk);
            end
            emerg_async = steps[i].emerg;
            ped_async = steps[i].ped;
            if (steps[i].timeout > 0) begin
                wait_change(i, steps[i].timeout, seen);
                if (!seen) begin
                    break;
                end
                // One tick of slack for synchronizer and tick alignment
                elapsed = (cyc - t_mark) / traffic_pkg::TICK_DIV;
                if (elapsed < steps[i].exp_ticks - 1 || elapsed > steps[i].exp_ticks + 1) begin
                    errors++;
                    $display("Step %0d changed after %0d ticks, expected %0d give or take one",
                             i, elapsed, steps[i].exp_ticks);
                end
                t_mark = cyc;
            end
            check_step(i);
            if (i == 0) begin
                check_blink();
            end
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* traffic_top.sv */
// Corridor top level: input conditioner, one controller per intersection
// and the shared lamp driver. Lamp lines are levels, bit k is intersection k
`timescale 1ns/1ps

module traffic_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  traffic_pkg::emerg_t             emerg_async,
    input  logic [traffic_pkg::NUM_X-1:0]   ped_async,
    output logic [traffic_pkg::NUM_X-1:0]   ns_red,
    output logic [traffic_pkg::NUM_X-1:0]   ns_yellow,
    output logic [traffic_pkg::NUM_X-1:0]   ns_green,
    output logic [traffic_pkg::NUM_X-1:0]   ew_red,
    output logic [traffic_pkg::NUM_X-1:0]   ew_yellow,
    output logic [traffic_pkg::NUM_X-1:0]   ew_green,
    output logic [traffic_pkg::NUM_X-1:0]   ped_walk,
    output logic                            flash_active
);

    // Conditioned inputs, emergency broadcast to all
    traffic_pkg::emerg_t                            emerg;
    logic [traffic_pkg::NUM_X-1:0]                  ped;
    logic                                           sec_tick;

    // Collected controller outputs
    traffic_pkg::light_t [traffic_pkg::NUM_X-1:0]   ns_light;
    traffic_pkg::light_t [traffic_pkg::NUM_X-1:0]   ew_light;
    logic [traffic_pkg::NUM_X-1:0]                  walk;

    input_conditioner input_conditioner_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .emerg_async (emerg_async),
        .ped_async   (ped_async),
        .emerg       (emerg),
        .ped         (ped),
        .sec_tick    (sec_tick)
    );

    for (genvar k = 0; k < traffic_pkg::NUM_X; k++) begin : gen_x
        intersection_fsm intersection_fsm_i (
            .clk      (clk),
            .reset_n  (reset_n),
            .sec_tick (sec_tick),
            .emerg    (emerg),
            .ped      (ped[k]),
            .ns_light (ns_light[k]),
            .ew_light (ew_light[k]),
            .walk     (walk[k])
        );
    end

    lamp_driver lamp_driver_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .sec_tick     (sec_tick),
        .ns_light     (ns_light),
        .ew_light     (ew_light),
        .walk         (walk),
        .ns_red       (ns_red),
        .ns_yellow    (ns_yellow),
        .ns_green     (ns_green),
        .ew_red       (ew_red),
        .ew_yellow    (ew_yellow),
        .ew_green     (ew_green),
        .ped_walk     (ped_walk),
        .flash_active (flash_active)
    );

endmodule
